// File: tb/ising_vectors.txt
// Columns in hex: op addr data expect
// op 1 read, 0 write then read back, 2 sample with expected spins
1 0 0 7
1 1 0 7
1 2 0 7
1 3 0 7
1 4 0 7
1 5 0 7
1 6 0 7
1 7 0 7
0 0 3 3
0 1 c c
0 2 0 0
0 3 e e
0 4 5 5
0 5 9 9
0 6 1 1
0 7 b b
2 0 0 0

// File: filelist.f
logic/ising_pkg.sv
logic/delay_buffer.sv
logic/coupled_cell.sv
logic/weight_write_decode.sv
logic/spin_sampler.sv
logic/ising_array.sv
tb/ising_array_sva.sv
tb/ising_array_tb.sv

// File: Makefile
# Verilator simulation of the coupled-oscillator array
# Run from the project root: make sim, make clean

VERILATOR ?= verilator
TOP       ?= ising_array_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Simulator exited with an error" >> $(LOG)
	@cat $(LOG)
	@if grep -q -e "ERRORS FOUND" -e "Simulator exited with an error" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/ising_array_tb.sv
/*
 * Replays tb/ising_vectors.txt, then random writes, idle strobes and sampling.
 * Run from the project root so that the vector path resolves.
 * ising_rstn stays low, so every cell passes its phases straight through.
 */
`timescale 1ns/1ps

module ising_array_tb;

    import ising_pkg::*;

    localparam int RST_CYCLES  = 16;
    localparam int PHASE_HALF  = 10;
    localparam int MAX_VEC     = 32;
    localparam int NUM_ADDR    = 2 ** ADDR_W;
    localparam int NUM_RAND    = 12;
    localparam int WAIT_LIMIT  = 4 * SAMPLE_WINDOW;
    localparam int WATCHDOG_NS = 200_000;

    // Vector operations, first column of the vector file
    localparam int OP_WRITE  = 0;
    localparam int OP_READ   = 1;
    localparam int OP_SAMPLE = 2;

    logic                  clk;
    logic                  axi_rstn;
    logic                  ising_rstn;
    logic                  phase_in = 1'b0;
    logic                  wready;
    logic [ADDR_W-1:0]     waddr;
    logic [WEIGHT_W-1:0]   wdata;
    logic [ADDR_W-1:0]     raddr;
    logic                  sample_start;
    logic [WEIGHT_W-1:0]   rdata;
    logic [NUM_CELLS-1:0]  spins;
    logic                  sample_done;

    // Four hex words per vector, op addr data expect
    logic [7:0]            vec_mem [4*MAX_VEC];
    // Expected weight per address
    logic [WEIGHT_W-1:0]   model [NUM_ADDR];
    integer                seed;
    int                    errors;
    int                    tests_run;
    int                    tests_failed;
    int                    phase_cnt = 0;

    ising_array dut (
        .clk          (clk),
        .axi_rstn     (axi_rstn),
        .ising_rstn   (ising_rstn),
        .phase_in     (phase_in),
        .wready       (wready),
        .waddr        (waddr),
        .wdata        (wdata),
        .raddr        (raddr),
        .sample_start (sample_start),
        .rdata        (rdata),
        .spins        (spins),
        .sample_done  (sample_done)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // External phase, toggles every PHASE_HALF clocks on the falling edge
    always @(negedge clk) begin
        if (phase_cnt == PHASE_HALF - 1) begin
            phase_cnt <= 0;
            phase_in  <= ~phase_in;
        end else begin
            phase_cnt <= phase_cnt + 1;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers, all entered and left on a falling edge
    // ------------------------------------------------------------------------

    task automatic check_value(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // Strobe for one clock, then one more clock for the cell to load
    task automatic write_weight(input int addr, input int data);
        wready      = 1'b1;
        waddr       = ADDR_W'(addr);
        wdata       = WEIGHT_W'(data);
        model[addr] = WEIGHT_W'(data);
        @(negedge clk);
        wready = 1'b0;
        @(negedge clk);
    endtask

    // One clock of read latency
    task automatic read_weight(input int addr, output int value);
        raddr = ADDR_W'(addr);
        @(negedge clk);
        value = int'(rdata);
    endtask

    task automatic check_weights(input string name);
        int value;
        for (int a = 0; a < NUM_ADDR; a++) begin
            read_weight(a, value);
            check_value($sformatf("%s addr %0d", name, a), int'(model[a]), value);
        end
    endtask

    // Start a window, optionally pulse start again a quarter way in
    task automatic run_sample(input string name, input int expected, input bit restart);
        int cycles;
        int pulses;
        sample_start = 1'b1;
        @(negedge clk);
        sample_start = 1'b0;
        cycles       = 0;
        while (!sample_done && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            sample_start = restart && (cycles == SAMPLE_WINDOW / 4);
        end
        sample_start = 1'b0;
        if (!sample_done) begin
            $display("Timeout: sample_done did not rise within %0d clocks in %s",
                     WAIT_LIMIT, name);
            errors++;
        end else begin
            check_value({name, " window"}, SAMPLE_WINDOW, cycles);
            check_value({name, " spins"}, expected, int'(spins));
            // Look one more window ahead for a stray pulse
            pulses = 1;
            for (int i = 0; i < SAMPLE_WINDOW + 8; i++) begin
                @(negedge clk);
                if (sample_done) begin
                    pulses++;
                end
            end
            check_value({name, " done pulses"}, 1, pulses);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %-24s ok", name);
        end else begin
            tests_failed++;
            $display("test %-24s failed", name);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        int    op;
        int    addr;
        int    data;
        int    expect_val;
        int    value;
        int    errs;
        int    idx;
        int    rnd;
        string name;

        clk          = 1'b0;
        axi_rstn     = 1'b0;
        ising_rstn   = 1'b0;
        wready       = 1'b0;
        waddr        = '0;
        wdata        = '0;
        raddr        = '0;
        sample_start = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = 32'h2992_2a47;

        // 8'hff marks the end of the vectors
        for (int i = 0; i < 4 * MAX_VEC; i++) begin
            vec_mem[i] = 8'hff;
        end
        for (int a = 0; a < NUM_ADDR; a++) begin
            model[a] = WEIGHT_W'(NUM_WEIGHTS / 2);
        end
        $readmemh("tb/ising_vectors.txt", vec_mem);

        repeat (RST_CYCLES) @(negedge clk);
        axi_rstn = 1'b1;
        @(negedge clk);

        // Vector replay
        idx = 0;
        while (idx < MAX_VEC && vec_mem[4*idx] != 8'hff) begin
            op         = int'(vec_mem[4*idx]);
            addr       = int'(vec_mem[4*idx+1]);
            data       = int'(vec_mem[4*idx+2]);
            expect_val = int'(vec_mem[4*idx+3]);
            name       = $sformatf("vector %0d", idx);
            errs       = errors;
            case (op)
                OP_WRITE: begin
                    write_weight(addr, data);
                    read_weight(addr, value);
                    check_value(name, expect_val, value);
                    // Other seven weights must be untouched
                    check_weights(name);
                end
                OP_READ: begin
                    read_weight(addr, value);
                    check_value(name, expect_val, value);
                end
                OP_SAMPLE: run_sample(name, expect_val, 1'b0);
                default: begin
                    $display("Vector %0d has an unknown operation %0d", idx, op);
                    errors++;
                end
            endcase
            end_test(name, errs);
            idx++;
        end
        if (idx == 0) begin
            $display("No vectors were read from tb/ising_vectors.txt");
            errors++;
        end

        errs = errors;
        for (int i = 0; i < NUM_RAND; i++) begin
            rnd  = $random(seed);
            addr = rnd & (NUM_ADDR - 1);
            data = ((rnd >> 8) & 255) % NUM_WEIGHTS;
            write_weight(addr, data);
            check_weights($sformatf("random write %0d", i));
        end
        end_test("random writes", errs);

        // Address and data move while wready stays low
        errs = errors;
        for (int i = 0; i < 8; i++) begin
            rnd   = $random(seed);
            waddr = ADDR_W'(rnd);
            wdata = WEIGHT_W'(rnd >> 4);
            @(negedge clk);
        end
        check_weights("idle strobes");
        end_test("writes without wready", errs);

        errs = errors;
        run_sample("pass-through sample", 0, 1'b0);
        end_test("pass-through sample", errs);

        errs = errors;
        run_sample("restart ignored", 0, 1'b1);
        end_test("restart ignored", errs);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Last resort against a hung run
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: tb/ising_array_sva.sv
/*
 * Checks on the registered write select and the sampler done pulse.
 * Bound into weight_write_decode and into spin_sampler.
 * A port that the bound module lacks is tied low.
 */
`timescale 1ns/1ps

module ising_array_sva (
    input logic                            clk,
    input logic                            axi_rstn,
    input logic [ising_pkg::NUM_CELLS-1:0] wr_sel,
    input logic                            done
);

    // Never more than one cell selected
    a_sel_onehot0: assert property (@(posedge clk) disable iff (!axi_rstn)
        $onehot0(wr_sel))
        else $error("write select has more than one cell");

    // Done is a single clock pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!axi_rstn)
        done |=> !done)
        else $error("sample_done held for more than one clock");

endmodule

bind weight_write_decode ising_array_sva u_wr_sva (
    .clk       (clk),
    .axi_rstn  (axi_rstn),
    .wr_sel    (weight_wr.sel),
    .done      (1'b0)
);

bind spin_sampler ising_array_sva u_smp_sva (
    .clk       (clk),
    .axi_rstn  (axi_rstn),
    .wr_sel    ({ising_pkg::NUM_CELLS{1'b0}}),
    .done      (sample_done)
);

// File: logic/ising_array.sv
/*
 * Top of the 2x2 coupled-oscillator array with weight access and spin readout.
 * Left and top edges are driven by phase_in, right and bottom edges loop back.
 * A written weight is readable on the third clock edge after its strobe.
 */
`timescale 1ns/1ps

module ising_array (
    input  logic                              clk,
    input  logic                              axi_rstn,
    input  logic                              ising_rstn,
    input  logic                              phase_in,
    input  logic                              wready,
    input  logic [ising_pkg::ADDR_W-1:0]      waddr,
    input  logic [ising_pkg::WEIGHT_W-1:0]    wdata,
    input  logic [ising_pkg::ADDR_W-1:0]      raddr,
    input  logic                              sample_start,
    output logic [ising_pkg::WEIGHT_W-1:0]    rdata,
    output logic [ising_pkg::NUM_CELLS-1:0]   spins,
    output logic                              sample_done
);

    import ising_pkg::*;

    weight_wr_t            weight_wr;
    coupling_dir_e         rd_dir;
    logic [CELL_IDX_W-1:0] rd_cell;

    // Cell outputs, index r * ARRAY_N + c
    wire  [NUM_CELLS-1:0]  lout_w;
    wire  [NUM_CELLS-1:0]  rout_w;
    wire  [NUM_CELLS-1:0]  tout_w;
    wire  [NUM_CELLS-1:0]  bout_w;
    wire  [WEIGHT_W-1:0]   cell_rdata [NUM_CELLS];

    // Write decode, one clock
    weight_write_decode u_wr_dec (
        .clk       (clk),
        .axi_rstn  (axi_rstn),
        .wready    (wready),
        .waddr     (waddr),
        .wdata     (wdata),
        .weight_wr (weight_wr)
    );

    assign rd_cell = raddr[ADDR_W-1:1];
    assign rd_dir  = coupling_dir_e'(raddr[0]);

    // ------------------------------------------------------------------------
    // Cell grid
    // ------------------------------------------------------------------------

    for (genvar r = 0; r < ARRAY_N; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_N; c++) begin : g_col
            localparam int IDX = r * ARRAY_N + c;

            wire lin_c;
            wire rin_c;
            wire tin_c;
            wire bin_c;

            // Left and top edges take the external phase
            if (c == 0) begin : g_edge_l
                assign lin_c = phase_in;
            end else begin : g_link_l
                assign lin_c = rout_w[IDX-1];
            end
            if (r == 0) begin : g_edge_t
                assign tin_c = phase_in;
            end else begin : g_link_t
                assign tin_c = bout_w[IDX-ARRAY_N];
            end

            // Right and bottom edges fold the cell's own output back
            if (c == ARRAY_N - 1) begin : g_edge_r
                assign rin_c = rout_w[IDX];
            end else begin : g_link_r
                assign rin_c = lout_w[IDX+1];
            end
            if (r == ARRAY_N - 1) begin : g_edge_b
                assign bin_c = bout_w[IDX];
            end else begin : g_link_b
                assign bin_c = tout_w[IDX+ARRAY_N];
            end

            coupled_cell u_cell (
                .ising_rstn (ising_rstn),
                .lin        (lin_c),
                .rin        (rin_c),
                .tin        (tin_c),
                .bin        (bin_c),
                .lout       (lout_w[IDX]),
                .rout       (rout_w[IDX]),
                .tout       (tout_w[IDX]),
                .bout       (bout_w[IDX]),
                .clk        (clk),
                .axi_rstn   (axi_rstn),
                .weight_wr  (weight_wr),
                .cell_sel   (weight_wr.sel[IDX]),
                .dir_rd     (rd_dir),
                .rdata      (cell_rdata[IDX])
            );
        end
    end

    // Registered weight read, one clock from raddr
    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            rdata <= '0;
        end else begin
            rdata <= cell_rdata[rd_cell];
        end
    end

    // Spin readout from each cell's rout
    spin_sampler u_sampler (
        .clk          (clk),
        .axi_rstn     (axi_rstn),
        .phase_in     (phase_in),
        .cell_phase   (rout_w),
        .sample_start (sample_start),
        .spins        (spins),
        .sample_done  (sample_done)
    );

endmodule

// File: logic/spin_sampler.sv
/*
 * Measures each cell phase against phase_in over SAMPLE_WINDOW clocks.
 * Both sides pass the same two flops, so their lag cancels.
 * A start pulse during a running window is ignored.
 */
`timescale 1ns/1ps

module spin_sampler (
    input  logic                              clk,
    input  logic                              axi_rstn,
    input  logic                              phase_in,
    input  logic [ising_pkg::NUM_CELLS-1:0]   cell_phase,
    input  logic                              sample_start,
    output logic [ising_pkg::NUM_CELLS-1:0]   spins,
    output logic                              sample_done
);

    import ising_pkg::*;

    // Top bit carries phase_in alongside the cell phases
    logic [NUM_CELLS:0]      sync_meta;
    logic [NUM_CELLS:0]      sync_q;
    logic [NUM_CELLS-1:0]    mismatch;
    sample_state_e           state;
    logic [SAMPLE_CNT_W-1:0] win_cnt;
    logic [SAMPLE_CNT_W-1:0] mis_cnt  [NUM_CELLS];
    logic [SAMPLE_CNT_W-1:0] cnt_next [NUM_CELLS];
    logic                    win_last;

    // Two-flop synchroniser for the asynchronous phases
    always_ff @(posedge clk) begin
        sync_meta <= {phase_in, cell_phase};
        sync_q    <= sync_meta;
    end

    always_comb begin
        for (int c = 0; c < NUM_CELLS; c++) begin
            mismatch[c] = sync_q[c] ^ sync_q[NUM_CELLS];
            cnt_next[c] = mis_cnt[c] + SAMPLE_CNT_W'(mismatch[c]);
        end
    end

    assign win_last = (state == SAMPLE_COUNT) &&
                      (win_cnt == SAMPLE_CNT_W'(SAMPLE_WINDOW - 1));

    // Mismatch counters, held at zero between windows
    always_ff @(posedge clk) begin
        for (int c = 0; c < NUM_CELLS; c++) begin
            mis_cnt[c] <= (state == SAMPLE_IDLE) ? '0 : cnt_next[c];
        end
    end

    // ------------------------------------------------------------------------
    // Window FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            state       <= SAMPLE_IDLE;
            win_cnt     <= '0;
            spins       <= '0;
            sample_done <= 1'b0;
        end else begin
            sample_done <= 1'b0;
            case (state)
                SAMPLE_IDLE: begin
                    if (sample_start) begin
                        state   <= SAMPLE_COUNT;
                        win_cnt <= '0;
                    end
                end
                SAMPLE_COUNT: begin
                    win_cnt <= win_cnt + SAMPLE_CNT_W'(1);
                    if (win_last) begin
                        // Spin is 1 when mismatches are the majority
                        for (int c = 0; c < NUM_CELLS; c++) begin
                            spins[c] <= cnt_next[c] > SAMPLE_CNT_W'(SAMPLE_WINDOW / 2);
                        end
                        sample_done <= 1'b1;
                        state       <= SAMPLE_IDLE;
                    end
                end
                default: state <= SAMPLE_IDLE;
            endcase
        end
    end

endmodule

// File: logic/weight_write_decode.sv
/*
 * Registers one weight write per wready strobe, with no back-pressure.
 * The one-hot select is valid for exactly one clock per strobe.
 */
`timescale 1ns/1ps

module weight_write_decode (
    input  logic                             clk,
    input  logic                             axi_rstn,
    input  logic                             wready,
    input  logic [ising_pkg::ADDR_W-1:0]     waddr,
    input  logic [ising_pkg::WEIGHT_W-1:0]   wdata,
    output ising_pkg::weight_wr_t            weight_wr
);

    import ising_pkg::*;

    logic [CELL_IDX_W-1:0] cell_idx;
    logic [NUM_CELLS-1:0]  cell_onehot;
    coupling_dir_e         wr_dir;

    // ------------------------------------------------------------------------
    // Address split
    // ------------------------------------------------------------------------

    // High bits name the cell, bit 0 the direction
    assign cell_idx = waddr[ADDR_W-1:1];
    assign wr_dir   = coupling_dir_e'(waddr[0]);

    always_comb begin
        cell_onehot           = '0;
        cell_onehot[cell_idx] = 1'b1;
    end

    // ------------------------------------------------------------------------
    // Write register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            weight_wr <= '0;
        end else begin
            // Select drops back to zero on any clock without a strobe
            weight_wr.sel <= wready ? cell_onehot : '0;
            if (wready) begin
                weight_wr.dir  <= wr_dir;
                weight_wr.data <= wdata;
            end
        end
    end

endmodule

// File: logic/coupled_cell.sv
/*
 * One coupling cell of the oscillator grid, with a vh and an hv weight.
 * Phase paths are asynchronous and only the weight registers use clk.
 * ising_rstn low makes every output follow its opposite input directly.
 */
`timescale 1ns/1ps

module coupled_cell #(
    parameter int  NUM_LUTS    = 1,
    parameter real STAGE_DELAY = 0.25
) (
    // Oscillator reset
    input  logic                               ising_rstn,

    // Asynchronous phase inputs and outputs
    input  logic                               lin,
    input  logic                               rin,
    input  logic                               tin,
    input  logic                               bin,
    output logic                               lout,
    output logic                               rout,
    output logic                               tout,
    output logic                               bout,

    // Weight access, synchronous to clk
    input  logic                               clk,
    input  logic                               axi_rstn,
    input  ising_pkg::weight_wr_t              weight_wr,
    input  logic                               cell_sel,
    input  ising_pkg::coupling_dir_e           dir_rd,
    output logic [ising_pkg::WEIGHT_W-1:0]     rdata
);

    import ising_pkg::*;

    // Paths: 0 lin to rout, 1 bin to tout, 2 rin to lout, 3 tin to bout
    localparam int NUM_PATHS  = 4;
    localparam int NUM_SLICES = WEIGHT_W - 1;

    logic [WEIGHT_W-1:0]  weight_vh;
    logic [WEIGHT_W-1:0]  weight_hv;

    wire  [NUM_PATHS-1:0] path_in;
    wire  [NUM_PATHS-1:0] path_out;
    wire  [NUM_PATHS-1:0] ref_out;

    // ------------------------------------------------------------------------
    // Weight registers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            weight_vh <= WEIGHT_W'(WEIGHT_RESET);
            weight_hv <= WEIGHT_W'(WEIGHT_RESET);
        end else if (cell_sel) begin
            // Only the addressed direction is loaded
            if (weight_wr.dir == DIR_VH) begin
                weight_vh <= weight_wr.data;
            end else begin
                weight_hv <= weight_wr.data;
            end
        end
    end

    // Read side, registered by the array top
    assign rdata = (dir_rd == DIR_VH) ? weight_vh : weight_hv;

    // Path inputs, path outputs, and the output each path is compared with
    assign path_in = {tin, rin, bin, lin};
    assign ref_out = {lout, bout, rout, tout};
    assign {bout, lout, tout, rout} = path_out;

    // ------------------------------------------------------------------------
    // Delay chains
    //
    // Each weight bit above bit 0 owns one slice of both chains, with a
    // delay of 1, 1, 2, 4 ... stages. The mismatch chain switches a slice in
    // when its bit is set, the match chain when it is clear. Bit 0 adds one
    // extra stage to the match chain of the rin and tin paths only, so the
    // weight is split evenly between the two paths of a direction.
    // Weight 7 gives equal delays on both chains, no coupling.
    // ------------------------------------------------------------------------

    for (genvar p = 0; p < NUM_PATHS; p++) begin : g_path
        // Even paths run horizontally and use vh
        wire [WEIGHT_W-1:0]   w;
        wire [NUM_SLICES-1:0] match_tap;
        wire [NUM_SLICES-1:0] mism_tap;
        wire                  sel_tap;
        wire                  hold_out;
        wire                  rst_out;

        assign w = (p % 2 == 0) ? weight_vh : weight_hv;

        for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
            localparam int SLICE_LUTS = (i == 0) ? NUM_LUTS : NUM_LUTS * (1 << (i - 1));

            wire match_in;
            wire mism_in;
            wire mism_dly;

            if (i == 0) begin : g_head
                assign match_in = path_in[p];
                assign mism_in  = path_in[p];
            end else begin : g_link
                assign match_in = match_tap[i-1];
                assign mism_in  = mism_tap[i-1];
            end

            // Mismatch chain, slice present when the bit is set
            delay_buffer #(
                .NUM_LUTS    (SLICE_LUTS),
                .STAGE_DELAY (STAGE_DELAY)
            ) u_mism (
                .in  (mism_in),
                .out (mism_dly)
            );
            assign mism_tap[i] = w[i+1] ? mism_dly : mism_in;

            if (i == 0 && p < 2) begin : g_skip
                // No bit 0 slice on the lin and bin paths
                assign match_tap[i] = match_in;
            end else begin : g_match
                localparam int MATCH_BIT = (i == 0) ? 0 : i + 1;

                wire match_dly;

                delay_buffer #(
                    .NUM_LUTS    (SLICE_LUTS),
                    .STAGE_DELAY (STAGE_DELAY)
                ) u_match (
                    .in  (match_in),
                    .out (match_dly)
                );
                assign match_tap[i] = w[MATCH_BIT] ? match_in : match_dly;
            end
        end

        // Chain choice by phase relation, a high weight slows a mismatched
        // destination and speeds up a matched one
        assign sel_tap = (path_in[p] == ref_out[p]) ? match_tap[NUM_SLICES-1]
                                                    : mism_tap[NUM_SLICES-1];

        // Anti-glitch hold, an output that already equals its input stays
        assign hold_out = (path_out[p] == path_in[p]) ? path_out[p] : sel_tap;

        // Oscillator reset bypasses the delay chains
        assign rst_out = ising_rstn ? hold_out : path_in[p];

        // Output stage keeps the output to input feedback loop stable
        delay_buffer #(
            .NUM_LUTS    (NUM_LUTS),
            .STAGE_DELAY (STAGE_DELAY)
        ) u_out (
            .in  (rst_out),
            .out (path_out[p])
        );
    end

endmodule

// File: logic/delay_buffer.sv
/*
 * Behavioural phase delay for simulation only, not a synthesis target.
 * Delay is NUM_LUTS stages of STAGE_DELAY ns, transport style.
 */
`timescale 1ns/1ps

module delay_buffer #(
    parameter int  NUM_LUTS    = 1,
    parameter real STAGE_DELAY = 0.25
) (
    input  logic in,
    output logic out
);

    // Total delay of the slice in ns
    localparam real TOTAL_DELAY = NUM_LUTS * STAGE_DELAY;

    // ------------------------------------------------------------------------
    // Transport delay
    // ------------------------------------------------------------------------

    // Every edge is scheduled on its own, so short pulses
    // survive the buffer instead of being swallowed
    always @(in) begin
        out <= #(TOTAL_DELAY) in;
    end

    // A chain of these forms one delay slice of a coupling cell,
    // and a single stage isolates each cell output from its
    // own feedback path

endmodule

// File: logic/ising_pkg.sv
/*
 * Sizes, write record and enums shared by the oscillator array.
 * NUM_WEIGHTS must stay odd: its half is the zero-coupling reset weight.
 * The address low bit picks the coupling direction, the high bits the cell.
 */
package ising_pkg;

    // ------------------------------------------------------------------------
    // Array geometry
    // ------------------------------------------------------------------------

    // Cells per side, the grid is square
    localparam int ARRAY_N    = 2;
    localparam int NUM_CELLS  = ARRAY_N * ARRAY_N;
    localparam int CELL_IDX_W = $clog2(NUM_CELLS);

    // ------------------------------------------------------------------------
    // Coupling weights
    // ------------------------------------------------------------------------

    // Number of weight levels, odd so that the middle level means no coupling
    localparam int NUM_WEIGHTS  = 15;
    localparam int WEIGHT_W     = $clog2(NUM_WEIGHTS);
    localparam int WEIGHT_RESET = NUM_WEIGHTS / 2;

    // Write and read address, {cell index, direction}
    localparam int ADDR_W = CELL_IDX_W + 1;

    // Spin measurement window in clocks
    localparam int SAMPLE_WINDOW = 64;
    // Wide enough to hold a full window of mismatches
    localparam int SAMPLE_CNT_W  = $clog2(SAMPLE_WINDOW + 1);

    // Which of the two weights of a cell is addressed
    typedef enum logic {
        DIR_HV = 1'b0,
        DIR_VH = 1'b1
    } coupling_dir_e;

    // Registered write command as seen by the cells
    typedef struct packed {
        logic [NUM_CELLS-1:0] sel;   // One-hot cell select, zero when idle
        coupling_dir_e        dir;
        logic [WEIGHT_W-1:0]  data;
    } weight_wr_t;

    // Spin sampler states
    typedef enum logic {
        SAMPLE_IDLE,
        SAMPLE_COUNT
    } sample_state_e;

endpackage
